// ==== bus_region_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_region_decode
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire        clk_rv,
    input  wire        rst_rv,
    input  bus_addr_t  mem_la_addr,
    input  wire        mem_valid,
    input  wire        mem_ready,
    input  wire        cpu_resetn,
    output region_e    region,
    output logic       ram_valid,
    output logic       gpio_valid,
    output logic       flash_valid,
    output logic       cpu_irq
);

    region_e la_region;     // Decode of the look-ahead address
    logic    mem_valid_d;   // For rising edge of mem_valid

    always_comb begin
        if (mem_la_addr >= RAM_BASE) begin
            la_region = REGION_RAM;
        end else if ((mem_la_addr >= GPIO_BASE) && (mem_la_addr < GPIO_LIMIT)) begin
            la_region = REGION_GPIO;
        end else if ((mem_la_addr >= FLASH_BASE) && (mem_la_addr < FLASH_LIMIT)) begin
            la_region = REGION_FLASH;
        end else begin
            la_region = REGION_NONE;
        end
    end

    // Region is ready by the time mem_valid rises
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region <= REGION_NONE;
        end else begin
            region <= la_region;
        end
    end

    assign ram_valid   = mem_valid && !mem_ready && (region == REGION_RAM);
    assign gpio_valid  = mem_valid && !mem_ready && (region == REGION_GPIO);
    assign flash_valid = mem_valid && (region == REGION_FLASH);  // Held until flash answers

    // -----------------------------------------------------------------------
    // Bus fault interrupt
    // -----------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv || !cpu_resetn) begin
            mem_valid_d <= 1'b0;
            cpu_irq     <= 1'b0;        // Only a CPU reset clears the fault
        end else begin
            mem_valid_d <= mem_valid;
            if (mem_valid && !mem_valid_d && (region == REGION_NONE)) begin
                cpu_irq <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bus_response.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_response
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire        clk_rv,
    input  wire        rst_rv,
    input  wire        mem_valid,
    input  region_e    region,
    input  wire        flash_ready,
    input  bus_data_t  ram_rdata,
    input  bus_data_t  gpio_rdata,
    input  bus_data_t  flash_rdata,
    output logic       mem_ready,
    output bus_data_t  mem_rdata
);

    logic default_ready;

    // One-cycle ready for every target without a ready of its own,
    // unmapped addresses included so the CPU never hangs
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            default_ready <= 1'b0;
        end else begin
            default_ready <= mem_valid && !mem_ready && (region != REGION_FLASH);
        end
    end

    assign mem_ready = default_ready || flash_ready;

    // -----------------------------------------------------------------------
    // Read data select
    // -----------------------------------------------------------------------

    always_comb begin
        case (region)
            REGION_RAM:   mem_rdata = ram_rdata;
            REGION_GPIO:  mem_rdata = gpio_rdata;
            REGION_FLASH: mem_rdata = flash_rdata;
            default:      mem_rdata = UNMAPPED_RDATA;  // Unmapped reads as all ones
        endcase
    end

endmodule

`default_nettype wire

// ==== gpio_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module gpio_regs
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire         clk_rv,
    input  wire         cpu_resetn,
    input  wire         gpio_valid,
    input  bus_addr_t   mem_addr,
    input  bus_data_t   mem_wdata,
    input  bus_strb_t   mem_wstrb,
    input  delay_sel_t  delay_sel_det,
    input  wire         i2c_sda_in,
    output bus_data_t   gpio_rdata,
    output delay_sel_t  delay_sel,
    output logic        led_red_n,
    output logic        led_green_n,
    output logic        z80_rst,
    output logic        i2c_scl,
    output logic        i2c_sda_low,
    output logic        usb_rst_n
);

    logic [3:0] reg_idx;
    logic       wr_en;
    logic       rd_en;
    logic       led_red;            // Active-high LED state
    logic       led_green;
    logic       i2c_sda;            // 1 releases the line

    assign reg_idx = mem_addr[5:2];
    assign wr_en   = gpio_valid && (mem_wstrb != 4'b0000);
    assign rd_en   = gpio_valid && (mem_wstrb == 4'b0000);

    // -----------------------------------------------------------------------
    // Control registers
    // -----------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!cpu_resetn) begin
            delay_sel <= delay_sel_det;     // Start from the detected tap
            led_red   <= 1'b0;
            led_green <= 1'b0;
            z80_rst   <= 1'b1;
            i2c_scl   <= 1'b1;
            i2c_sda   <= 1'b1;
            usb_rst_n <= 1'b0;              // USB held in reset until firmware
        end else if (wr_en) begin
            case (reg_idx)
                GPIO_REG_DELAY_SEL: delay_sel <= mem_wdata[4:0];
                GPIO_REG_LED_GREEN: led_green <= mem_wdata[0];
                GPIO_REG_LED_RED:   led_red   <= mem_wdata[0];
                GPIO_REG_Z80_RST:   z80_rst   <= mem_wdata[0];
                GPIO_REG_I2C_SCL:   i2c_scl   <= mem_wdata[0];
                GPIO_REG_I2C_SDA:   i2c_sda   <= mem_wdata[0];
                GPIO_REG_USB_RST:   usb_rst_n <= mem_wdata[0];
                default: ;                  // Index 4 and above 7 ignored
            endcase
        end
    end

    // Read data lands with the default ready
    always_ff @(posedge clk_rv) begin
        if (rd_en) begin
            case (reg_idx)
                GPIO_REG_DELAY_SEL: gpio_rdata <= {27'd0, delay_sel_det};
                GPIO_REG_Z80_RST:   gpio_rdata <= {31'd0, z80_rst};
                GPIO_REG_I2C_SDA:   gpio_rdata <= {31'd0, i2c_sda_in};
                default:            gpio_rdata <= '0;
            endcase
        end
    end

    // Pin side
    assign led_red_n   = !led_red;      // LEDs are active low
    assign led_green_n = !led_green;
    assign i2c_sda_low = !i2c_sda;      // Open drain, pull low only

endmodule

`default_nettype wire

// ==== hold_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module hold_counter #(
    parameter int HOLD_CYCLES = 16
) (
    input  wire   clk_rv,
    input  wire   clear,
    input  wire   enable,
    output logic  done
);

    localparam int                CNT_W    = $clog2(HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0]  TERMINAL = CNT_W'(HOLD_CYCLES);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_rv) begin
        if (clear) begin
            count <= '0;
        end else if (enable && !done) begin
            count <= count + 1'b1;          // Saturates at terminal count
        end
    end

    assign done = (count == TERMINAL);

endmodule

`default_nettype wire

// ==== onchip_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module onchip_ram
    import soc_bus_pkg::*;
#(
    parameter int RAM_WORDS = 2048
) (
    input  wire        clk_rv,
    input  wire        ram_valid,
    input  bus_addr_t  mem_addr,
    input  bus_data_t  mem_wdata,
    input  bus_strb_t  mem_wstrb,
    output bus_data_t  ram_rdata
);

    localparam int AW = $clog2(RAM_WORDS);

    byte_t [3:0]   mem [RAM_WORDS];     // Four byte lanes per word
    logic [AW-1:0] word_idx;

    // Upper address bits ignored, so the RAM repeats across its region
    assign word_idx = mem_addr[AW+1:2];

    always_ff @(posedge clk_rv) begin
        for (int i = 0; i < 4; i++) begin
            if (ram_valid && mem_wstrb[i]) begin
                mem[word_idx][i] <= mem_wdata[i*8 +: 8];
            end
        end
        ram_rdata <= mem[word_idx];     // Read every cycle
    end

endmodule

`default_nettype wire

// ==== reset_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer #(
    parameter int HOLD_CYCLES = 16
) (
    input  wire   clk_rv,
    input  wire   rst_rv,
    input  wire   init_done,
    output logic  cpu_resetn
);

    typedef enum logic [1:0] {
        ST_WAIT_INIT,
        ST_HOLD,
        ST_RUN
    } rst_state_e;

    rst_state_e state;
    rst_state_e state_next;
    logic       hold_done;

    always_comb begin
        state_next = state;
        if (!init_done) begin
            state_next = ST_WAIT_INIT;      // Memory lost init, start over
        end else begin
            case (state)
                ST_WAIT_INIT: state_next = ST_HOLD;
                ST_HOLD:      state_next = hold_done ? ST_RUN : ST_HOLD;
                default:      state_next = ST_RUN;
            endcase
        end
    end

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            state      <= ST_WAIT_INIT;
            cpu_resetn <= 1'b0;
        end else begin
            state      <= state_next;
            cpu_resetn <= (state_next == ST_RUN);
        end
    end

    // Counter sits cleared while waiting, runs only in hold
    hold_counter #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_hold_counter (
        .clk_rv (clk_rv),
        .clear  (state == ST_WAIT_INIT),
        .enable (state == ST_HOLD),
        .done   (hold_done)
    );

endmodule

`default_nettype wire

// ==== soc_bus_pkg.sv ====
`default_nettype none

// ---------------------------------------------------------------------------
// System bus widths
// ---------------------------------------------------------------------------

package soc_bus_pkg;

    typedef logic [31:0] bus_addr_t;    // Byte address on the CPU bus
    typedef logic [31:0] bus_data_t;    // Read and write data
    typedef logic [3:0]  bus_strb_t;    // One strobe per byte lane

    typedef logic [7:0]  byte_t;        // Single byte lane

    // Delay tap select for the external memory controller
    typedef logic [4:0]  delay_sel_t;

endpackage

`default_nettype wire

// ==== soc_fabric_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_fabric_top
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int RAM_WORDS   = 2048,
    parameter int HOLD_CYCLES = 16
) (
    input  wire         clk_rv,
    input  wire         rst_rv,
    input  wire         init_done,          // From the memory controller
    // CPU bus
    input  bus_addr_t   mem_la_addr,
    input  wire         mem_valid,
    input  bus_addr_t   mem_addr,
    input  bus_data_t   mem_wdata,
    input  bus_strb_t   mem_wstrb,
    output logic        mem_ready,
    output bus_data_t   mem_rdata,
    output logic        cpu_irq,
    output logic        cpu_resetn,
    // Flash cache port
    output logic        flash_valid,
    output logic [16:0] flash_addr,
    input  wire         flash_ready,
    input  bus_data_t   flash_rdata,
    // GPIO pins
    input  delay_sel_t  delay_sel_det,
    input  wire         i2c_sda_in,
    output delay_sel_t  delay_sel,
    output logic        led_red_n,
    output logic        led_green_n,
    output logic        z80_rst,
    output logic        i2c_scl,
    output logic        i2c_sda_low,
    output logic        usb_rst_n
);

    region_e   region;
    logic      ram_valid;
    logic      gpio_valid;
    bus_data_t ram_rdata;
    bus_data_t gpio_rdata;

    assign flash_addr = mem_addr[16:0];     // Offset inside the flash window

    // -----------------------------------------------------------------------
    // Bus decode and response
    // -----------------------------------------------------------------------

    bus_region_decode u_decode (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_la_addr (mem_la_addr),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .cpu_resetn  (cpu_resetn),
        .region      (region),
        .ram_valid   (ram_valid),
        .gpio_valid  (gpio_valid),
        .flash_valid (flash_valid),
        .cpu_irq     (cpu_irq)
    );

    bus_response u_response (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_valid   (mem_valid),
        .region      (region),
        .flash_ready (flash_ready),
        .ram_rdata   (ram_rdata),
        .gpio_rdata  (gpio_rdata),
        .flash_rdata (flash_rdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata)
    );

    // Targets
    onchip_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk_rv    (clk_rv),
        .ram_valid (ram_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .ram_rdata (ram_rdata)
    );

    gpio_regs u_gpio (
        .clk_rv        (clk_rv),
        .cpu_resetn    (cpu_resetn),
        .gpio_valid    (gpio_valid),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .delay_sel_det (delay_sel_det),
        .i2c_sda_in    (i2c_sda_in),
        .gpio_rdata    (gpio_rdata),
        .delay_sel     (delay_sel),
        .led_red_n     (led_red_n),
        .led_green_n   (led_green_n),
        .z80_rst       (z80_rst),
        .i2c_scl       (i2c_scl),
        .i2c_sda_low   (i2c_sda_low),
        .usb_rst_n     (usb_rst_n)
    );

    reset_sequencer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_rst_seq (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .init_done  (init_done),
        .cpu_resetn (cpu_resetn)
    );

endmodule

`default_nettype wire

// ==== soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

    import soc_bus_pkg::*;

    // -----------------------------------------------------------------------
    // Address map
    // -----------------------------------------------------------------------

    localparam bus_addr_t RAM_BASE    = 32'hFFFF_0000;  // Up to top of space, 8 KB echoed
    localparam bus_addr_t GPIO_BASE   = 32'h0300_0000;
    localparam bus_addr_t GPIO_LIMIT  = 32'h0300_0100;
    localparam bus_addr_t FLASH_BASE  = 32'h0E00_0000;  // 128 KB window of the SPI flash
    localparam bus_addr_t FLASH_LIMIT = 32'h0E02_0000;

    localparam bus_data_t UNMAPPED_RDATA = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_GPIO,
        REGION_FLASH
    } region_e;

    // GPIO register index, taken from address bits 5:2
    localparam logic [3:0] GPIO_REG_DELAY_SEL = 4'd0;  // R: detected, W: applied
    localparam logic [3:0] GPIO_REG_LED_GREEN = 4'd1;
    localparam logic [3:0] GPIO_REG_LED_RED   = 4'd2;
    localparam logic [3:0] GPIO_REG_Z80_RST   = 4'd3;
    localparam logic [3:0] GPIO_REG_I2C_SCL   = 4'd5;
    localparam logic [3:0] GPIO_REG_I2C_SDA   = 4'd6;  // Reads back the pin
    localparam logic [3:0] GPIO_REG_USB_RST   = 4'd7;

endpackage

`default_nettype wire

// ==== tb_soc_fabric.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_soc_fabric
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int RAM_WORDS   = 2048;
    localparam int HOLD_CYCLES = 16;
    localparam int DRIVE_DELAY = 10;              // Inputs change this long after the edge
    localparam bit [31:0] SEED = 32'h25abdc3e;
    localparam bus_data_t FLASH_XOR = 32'hA5A5_A5A5;

    // Rough length of each test in clock cycles sets the watchdog limit
    localparam int ACCESS_CYCLES = 3;
    localparam int TEST_CYCLES   = (10 + 6 + 2 * (HOLD_CYCLES + 3) + 4)     // Reset release
                                 + 22 * ACCESS_CYCLES                       // RAM
                                 + 14 * ACCESS_CYCLES                       // GPIO
                                 + 8 * (ACCESS_CYCLES + 7)                  // Flash
                                 + 3 * ACCESS_CYCLES + HOLD_CYCLES + 7;     // Unmapped

    logic        clk_rv;
    logic        rst_rv;
    logic        init_done;
    bus_addr_t   mem_la_addr;
    logic        mem_valid;
    bus_addr_t   mem_addr;
    bus_data_t   mem_wdata;
    bus_strb_t   mem_wstrb;
    logic        mem_ready;
    bus_data_t   mem_rdata;
    logic        cpu_irq;
    logic        cpu_resetn;
    logic        flash_valid;
    logic [16:0] flash_addr;
    logic        flash_ready;
    bus_data_t   flash_rdata;
    delay_sel_t  delay_sel_det;
    logic        i2c_sda_in;
    delay_sel_t  delay_sel;
    logic        led_red_n;
    logic        led_green_n;
    logic        z80_rst;
    logic        i2c_scl;
    logic        i2c_sda_low;
    logic        usb_rst_n;

    int          errors;
    int          tests_run;
    int          tests_failed;
    int          flash_delay;                     // Stall chosen for the next flash access
    logic [16:0] flash_seen_addr;

    soc_fabric_top #(
        .RAM_WORDS   (RAM_WORDS),
        .HOLD_CYCLES (HOLD_CYCLES)
    ) dut0 (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .init_done     (init_done),
        .mem_la_addr   (mem_la_addr),
        .mem_valid     (mem_valid),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .cpu_irq       (cpu_irq),
        .cpu_resetn    (cpu_resetn),
        .flash_valid   (flash_valid),
        .flash_addr    (flash_addr),
        .flash_ready   (flash_ready),
        .flash_rdata   (flash_rdata),
        .delay_sel_det (delay_sel_det),
        .i2c_sda_in    (i2c_sda_in),
        .delay_sel     (delay_sel),
        .led_red_n     (led_red_n),
        .led_green_n   (led_green_n),
        .z80_rst       (z80_rst),
        .i2c_scl       (i2c_scl),
        .i2c_sda_low   (i2c_sda_low),
        .usb_rst_n     (usb_rst_n)
    );

    initial begin
        clk_rv = 1'b0;
        forever #50 clk_rv = !clk_rv;
    end

    // ---------------------------------------------------------------------------
    // Bus checks on every edge
    // ---------------------------------------------------------------------------

    ready_with_valid: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        mem_ready |-> mem_valid)
    else begin
        errors++;
        $display("mem_ready was high with no access pending at %0t", $time);
    end

    // A stalled flash must hold the access open
    ready_follows_flash: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        flash_valid |-> (mem_ready == flash_ready))
    else begin
        errors++;
        $display("mismatch mem_ready: got %h, expected %h", $sampled(mem_ready),
                 $sampled(flash_ready));
    end

    task automatic wait_cycle();
        @(posedge clk_rv);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Byte lane i comes from the new word where strobe i is set
    function automatic bus_data_t merge_bytes(input bus_data_t old_word,
                                              input bus_data_t new_word,
                                              input bus_strb_t strb);
        bus_data_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic bus_addr_t gpio_addr(input logic [3:0] idx);
        return GPIO_BASE + {26'd0, idx, 2'b00};
    endfunction

    // Look-ahead address leads mem_valid by one cycle and stays through the access
    task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
                              input bus_strb_t wstrb, output bus_data_t rdata,
                              output int waits);
        mem_la_addr = addr;
        wait_cycle();
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        waits     = 0;
        @(negedge clk_rv);
        while (!mem_ready && waits < 20) begin
            waits++;
            @(negedge clk_rv);
        end
        assert (mem_ready) else begin
            errors++;
            $display("no mem_ready for the access to address %h", addr);
        end
        rdata = mem_rdata;
        wait_cycle();
        mem_valid = 1'b0;
        mem_wstrb = 4'h0;
    endtask

    // Counts edges from the init_done rise until cpu_resetn is seen high
    task automatic wait_cpu_release(output int edges);
        edges = 0;
        while (!cpu_resetn && edges < 4 * HOLD_CYCLES) begin
            @(posedge clk_rv);
            edges++;
            @(negedge clk_rv);
        end
    endtask

    task automatic check_gpio_reset();
        check_value("led_red_n", led_red_n, 1'b1);
        check_value("led_green_n", led_green_n, 1'b1);
        check_value("z80_rst", z80_rst, 1'b1);
        check_value("i2c_scl", i2c_scl, 1'b1);
        check_value("i2c_sda_low", i2c_sda_low, 1'b0);
        check_value("usb_rst_n", usb_rst_n, 1'b0);
        check_value("delay_sel", delay_sel, delay_sel_det);
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - start_errors);
        end
    endtask

    // ---------------------------------------------------------------------------
    // Flash cache model that answers after the chosen stall
    // ---------------------------------------------------------------------------

    initial begin
        forever begin
            @(negedge clk_rv);
            if (flash_valid) begin
                flash_seen_addr = flash_addr;
                repeat (flash_delay) @(posedge clk_rv);
                wait_cycle();
                flash_ready = 1'b1;
                flash_rdata = {15'd0, flash_addr} ^ FLASH_XOR;
                wait_cycle();
                flash_ready = 1'b0;
            end
        end
    end

    initial begin
        repeat (2 * TEST_CYCLES) @(posedge clk_rv);
        $display("timeout, the tests did not complete within %0d cycles", 2 * TEST_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int        start_errors;
        int        waits;
        int        edges;
        bus_data_t rdata;
        bus_data_t d0;
        bus_data_t d1;
        bus_addr_t addr;
        bus_strb_t strb;

        void'($urandom(SEED));
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        flash_delay   = 0;
        rst_rv        = 1'b0;
        init_done     = 1'b0;
        mem_la_addr   = '0;
        mem_valid     = 1'b0;
        mem_addr      = '0;
        mem_wdata     = '0;
        mem_wstrb     = 4'h0;
        flash_ready   = 1'b0;
        flash_rdata   = '0;
        delay_sel_det = 5'h13;
        i2c_sda_in    = 1'b1;
        repeat (10) @(posedge clk_rv);
        #DRIVE_DELAY;
        rst_rv = 1'b1;

        // CPU stays in reset until init done and then for HOLD_CYCLES+1 more edges
        start_errors = errors;
        repeat (5) begin
            @(negedge clk_rv);
            check_value("cpu_resetn", cpu_resetn, 1'b0);
        end
        check_value("mem_ready", mem_ready, 1'b0);
        check_value("cpu_irq", cpu_irq, 1'b0);
        check_value("flash_valid", flash_valid, 1'b0);
        check_gpio_reset();
        wait_cycle();
        init_done = 1'b1;
        wait_cpu_release(edges);
        check_value("cpu_resetn rise edge", edges, HOLD_CYCLES + 2);
        wait_cycle();
        init_done = 1'b0;
        @(negedge clk_rv);
        check_value("cpu_resetn", cpu_resetn, 1'b1);
        @(negedge clk_rv);
        check_value("cpu_resetn", cpu_resetn, 1'b0);
        wait_cycle();
        init_done = 1'b1;
        wait_cpu_release(edges);
        check_value("cpu_resetn rise edge", edges, HOLD_CYCLES + 2);
        wait_cycle();
        end_test("reset release", start_errors);

        // RAM
        start_errors = errors;
        bus_access(RAM_BASE + 32'h10, 32'h1122_3344, 4'hF, rdata, waits);
        check_value("mem_ready latency", waits, 1);
        bus_access(RAM_BASE + 32'h10, 32'hAABB_CCDD, 4'b0101, rdata, waits);
        check_value("mem_ready latency", waits, 1);
        bus_access(RAM_BASE + 32'h10, '0, 4'h0, rdata, waits);
        check_value("mem_rdata", rdata, merge_bytes(32'h1122_3344, 32'hAABB_CCDD, 4'b0101));
        check_value("mem_ready latency", waits, 1);
        bus_access(RAM_BASE + 32'h2010, '0, 4'h0, rdata, waits);   // 8 KB echo
        check_value("mem_rdata", rdata, merge_bytes(32'h1122_3344, 32'hAABB_CCDD, 4'b0101));
        repeat (6) begin
            addr = RAM_BASE + ($urandom_range(RAM_WORDS - 1, 0) << 2);
            d0   = $urandom;
            d1   = $urandom;
            strb = bus_strb_t'($urandom);
            bus_access(addr, d0, 4'hF, rdata, waits);
            bus_access(addr, d1, strb, rdata, waits);
            bus_access(addr + 32'h2000, '0, 4'h0, rdata, waits);
            check_value("mem_rdata", rdata, merge_bytes(d0, d1, strb));
            check_value("mem_ready latency", waits, 1);
        end
        end_test("ram", start_errors);

        // GPIO
        start_errors = errors;
        bus_access(gpio_addr(4'd1), 32'h1, 4'hF, rdata, waits);
        check_value("led_green_n", led_green_n, 1'b0);
        check_value("led_red_n", led_red_n, 1'b1);
        bus_access(gpio_addr(4'd2), 32'h1, 4'hF, rdata, waits);
        check_value("led_red_n", led_red_n, 1'b0);
        bus_access(gpio_addr(4'd1), 32'h0, 4'hF, rdata, waits);
        check_value("led_green_n", led_green_n, 1'b1);
        bus_access(gpio_addr(4'd3), 32'h0, 4'hF, rdata, waits);
        check_value("z80_rst", z80_rst, 1'b0);
        bus_access(gpio_addr(4'd3), '0, 4'h0, rdata, waits);
        check_value("mem_rdata", rdata, 32'h0);
        bus_access(gpio_addr(4'd3), 32'h1, 4'hF, rdata, waits);
        bus_access(gpio_addr(4'd3), '0, 4'h0, rdata, waits);
        check_value("mem_rdata", rdata, 32'h1);
        bus_access(gpio_addr(4'd5), 32'h0, 4'hF, rdata, waits);
        check_value("i2c_scl", i2c_scl, 1'b0);
        bus_access(gpio_addr(4'd6), 32'h0, 4'hF, rdata, waits);
        check_value("i2c_sda_low", i2c_sda_low, 1'b1);
        bus_access(gpio_addr(4'd7), 32'h1, 4'hF, rdata, waits);
        check_value("usb_rst_n", usb_rst_n, 1'b1);
        bus_access(gpio_addr(4'd0), '0, 4'h0, rdata, waits);
        check_value("mem_rdata", rdata, 32'h0000_0013);
        check_value("mem_ready latency", waits, 1);
        bus_access(gpio_addr(4'd0), 32'h0A, 4'hF, rdata, waits);
        check_value("delay_sel", delay_sel, 5'h0A);
        i2c_sda_in = 1'b0;
        bus_access(gpio_addr(4'd6), '0, 4'h0, rdata, waits);
        check_value("mem_rdata", rdata, 32'h0);
        i2c_sda_in = 1'b1;
        bus_access(gpio_addr(4'd6), '0, 4'h0, rdata, waits);
        check_value("mem_rdata", rdata, 32'h1);
        end_test("gpio", start_errors);

        // Flash with a random stall per access
        start_errors = errors;
        repeat (8) begin
            addr        = FLASH_BASE + ($urandom_range(32'h7FFF, 0) << 2);
            flash_delay = $urandom_range(7, 0);
            bus_access(addr, '0, 4'h0, rdata, waits);
            check_value("mem_rdata", rdata, {15'd0, addr[16:0]} ^ FLASH_XOR);
            check_value("flash_addr", flash_seen_addr, addr[16:0]);
            check_value("mem_ready latency", waits, flash_delay + 1);
        end
        end_test("flash", start_errors);

        // Unmapped read latches a fault that stays until the CPU is reset
        start_errors = errors;
        check_value("cpu_irq", cpu_irq, 1'b0);
        bus_access(32'h2000_0000, '0, 4'h0, rdata, waits);
        check_value("mem_rdata", rdata, 32'hFFFF_FFFF);
        check_value("mem_ready latency", waits, 1);
        check_value("cpu_irq", cpu_irq, 1'b1);
        bus_access(RAM_BASE + 32'h10, '0, 4'h0, rdata, waits);
        check_value("cpu_irq", cpu_irq, 1'b1);
        bus_access(gpio_addr(4'd0), '0, 4'h0, rdata, waits);
        check_value("cpu_irq", cpu_irq, 1'b1);
        init_done = 1'b0;
        repeat (3) @(negedge clk_rv);
        check_value("cpu_resetn", cpu_resetn, 1'b0);
        check_value("cpu_irq", cpu_irq, 1'b0);
        check_gpio_reset();
        wait_cycle();
        init_done = 1'b1;
        wait_cpu_release(edges);
        check_value("cpu_resetn rise edge", edges, HOLD_CYCLES + 2);
        end_test("unmapped", start_errors);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
soc_bus_pkg.sv
soc_map_pkg.sv
hold_counter.sv
reset_sequencer.sv
bus_region_decode.sv
bus_response.sv
onchip_ram.sv
gpio_regs.sv
soc_fabric_top.sv
tb_soc_fabric.sv
